// File: Bender.yml
package:
  name: soc_dbus

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/soc_bus_pkg.sv
      - hdl/flash_pkg.sv
      - hdl/dbus_decoder.sv
      - hdl/scratch_ram.sv
      - hdl/flash_wait_timer.sv
      - hdl/flash_fsm.sv
      - hdl/flash_datapath.sv
      - hdl/soc_toplevel.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/soc_props.sv
      - bench/soc_tb.sv

// File: bench/soc_props.sv
`timescale 1ns/1ps

module soc_props (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    start_i,
    input logic                    capture_hi_i,
    input logic                    busy_i,
    input logic                    ce_n_i,
    input logic                    oe_n_i,
    input flash_pkg::flash_state_e state_i
);

    import flash_pkg::*;

    int unsigned fail_count = 0;

    // output enable only with the chip selected.
    oe_needs_ce: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !oe_n_i |-> !ce_n_i)
        else begin
            $error("flash oe_n low while ce_n high");
            fail_count++;
        end

    start_sets_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_i == FL_IDLE && start_i) |=> busy_i)
        else begin
            $error("busy not raised after start");
            fail_count++;
        end

    capture_hi_ends: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        capture_hi_i |=> state_i == FL_IDLE)
        else begin
            $error("flash fsm not idle after capture_hi");
            fail_count++;
        end

    idle_deselects: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_i == FL_IDLE |-> ce_n_i)
        else begin
            $error("flash ce_n low in FL_IDLE");
            fail_count++;
        end

endmodule

bind flash_fsm soc_props u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .start_i      (start_i),
    .capture_hi_i (capture_hi_o),
    .busy_i       (busy_o),
    .ce_n_i       (ce_n_o),
    .oe_n_i       (oe_n_o),
    .state_i      (state_q)
);

// File: bench/soc_stimulus.txt
# test op address wdata be expected (hex except test)
# W write, R read vs expected, M RAM vs shadow, F flash start and poll, P poll, D flash data, I pins, X random
1 I 00000000 00000000 0 00000003
1 R BE000004 00000000 0 00000000
1 R BE000008 00000000 0 00000000
2 W 80000000 12345678 f 00000000
2 W 80000FFC CAFEF00D f 00000000
2 R 80000000 00000000 0 12345678
2 R 80000FFC 00000000 0 CAFEF00D
3 W 80000010 AABBCCDD f 00000000
3 W 80000010 00001122 3 00000000
3 W 80000010 99000000 8 00000000
3 M 80000010 00000000 0 00000000
3 W 80000014 11223344 f 00000000
3 W 80000014 00ABCD00 6 00000000
3 M 80000014 00000000 0 00000000
4 F BE000000 00000000 f 00000000
4 D BE000008 00000000 0 00000000
4 F BE000000 00000124 f 00000000
4 D BE000008 00000000 0 00000000
4 F BE000000 00FFFFF8 f 00000000
4 D BE000008 00000000 0 00000000
5 W BE000000 00000040 f 00000000
5 W BE000000 00000800 f 00000000
5 P BE000004 00000000 0 00000000
5 D BE000008 00000000 0 00000000
5 W 10000000 DEADBEEF f 00000000
5 R 10000000 00000000 0 00000000
6 X 80000100 000000C8 f 00000000

// File: bench/soc_tb.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module soc_tb;

    import soc_bus_pkg::*;
    import flash_pkg::*;

    localparam int MAX_LINES  = 1000;
    localparam int POLL_LIMIT = 20 * `FLASH_WAIT_CYCLES;
    localparam int RAND_BASE  = 64; // first word of the random region.

    logic        clk;
    logic        rst_n;
    bus_req_t    bus_req;
    logic [31:0] bus_rdata;
    flash_pins_t flash_pins;
    logic [15:0] flash_data;

    logic [31:0] shadow [2**`RAM_AW];
    logic        fl_pending; // flash read accepted and not yet polled idle.
    logic [31:0] fl_addr;
    logic        timed_out;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    int          cur_test;

    soc_toplevel UUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .bus_req_i    (bus_req),
        .bus_rdata_o  (bus_rdata),
        .flash_pins_o (flash_pins),
        .flash_data_i (flash_data)
    );

    always #50 clk = ~clk;

    // ==================================================
    // flash chip and reference models
    // ==================================================

    function automatic logic [15:0] flash_half(input logic [`FLASH_AW-1:0] h);
        return h[15:0] ^ 16'hA55A;
    endfunction

    function automatic logic [31:0] flash_word(input logic [31:0] byte_addr);
        logic [`FLASH_AW-1:0] h;
        h = `FLASH_AW'((byte_addr >> 2) << 1); // two halfwords per word.
        return {flash_half(h + 1'b1), flash_half(h)};
    endfunction

    function automatic bus_target_e target_of(input logic [31:0] addr);
        if ((addr - `RAM_BASE) < (32'd4 << `RAM_AW)) begin
            return TGT_RAM;
        end else if ((addr - `FLASH_BASE) < 32'd16) begin
            return TGT_FLASH;
        end
        return TGT_NONE;
    endfunction

    assign flash_data = (!flash_pins.ce_n && !flash_pins.oe_n) ?
                        flash_half(flash_pins.addr) : 16'h0;

    // ==================================================
    // bus access and checking
    // ==================================================

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic store_word(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be);
        int idx;
        idx = (addr - `RAM_BASE) >> 2;
        @(posedge clk);
        #1;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        bus_req.be    = be;
        bus_req.wr    = 1'b1;
        @(posedge clk);
        #1;
        bus_req.wr = 1'b0;
        if (target_of(addr) == TGT_RAM) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    shadow[idx][8*i +: 8] = wdata[8*i +: 8];
                end
            end
        end else if (target_of(addr) == TGT_FLASH && (addr - `FLASH_BASE) == 32'(FREG_ADDR)
                     && !fl_pending) begin
            fl_pending = 1'b1; // writes while busy are dropped.
            fl_addr    = wdata;
        end
    endtask

    task automatic load_word(input logic [31:0] addr, output logic [31:0] data);
        @(posedge clk);
        #1;
        bus_req.addr = addr;
        bus_req.rd   = 1'b1;
        @(posedge clk);
        #1;
        bus_req.rd = 1'b0;
        data = bus_rdata; // valid the cycle after the strobe.
    endtask

    task automatic wait_flash_idle();
        logic [31:0] status;
        int          cycles;
        status = 32'd1;
        cycles = 0;
        while (status[0] && !timed_out) begin
            if (cycles >= POLL_LIMIT) begin
                $display("flash read of address %h never finished within %0d cycles",
                         fl_addr, POLL_LIMIT);
                timed_out = 1'b1;
                errors++;
                test_errors++;
            end else begin
                load_word(`FLASH_BASE + 32'(FREG_STATUS), status);
                cycles += 2;
            end
        end
        if (!timed_out) begin
            fl_pending = 1'b0;
        end
    endtask

    task automatic random_ram(input int count);
        logic [31:0] addr;
        logic [31:0] data;
        int          idx;
        for (int i = 0; i < 16; i++) begin
            store_word(`RAM_BASE + 32'(4 * (RAND_BASE + i)), $urandom(), 4'hf);
        end
        for (int i = 0; i < count; i++) begin
            idx  = RAND_BASE + ($urandom() % 16);
            addr = `RAM_BASE + 32'(4 * idx);
            if ($urandom() % 2) begin
                store_word(addr, $urandom(), 4'($urandom()));
            end else begin
                load_word(addr, data);
                check(data, shadow[idx], $sformatf("random read at %h", addr));
            end
        end
    endtask

    task automatic run_op(input string op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] be,
                          input logic [31:0] exp);
        logic [31:0] data;
        bus_target_e tgt;
        tgt = target_of(addr);
        case (op)
            "W": store_word(addr, wdata, be);
            "F": begin
                store_word(addr, wdata, be);
                wait_flash_idle();
            end
            "P": wait_flash_idle();
            "R": begin
                load_word(addr, data);
                check(data, exp, $sformatf("%s read at %h", tgt.name(), addr));
            end
            "M": begin
                load_word(addr, data);
                check(data, shadow[(addr - `RAM_BASE) >> 2], $sformatf("RAM word at %h", addr));
            end
            "D": begin
                load_word(addr, data);
                check(data, flash_word(fl_addr), $sformatf("flash word for %h", fl_addr));
            end
            "I": check({30'd0, flash_pins.ce_n, flash_pins.oe_n}, exp, "flash pins at rest");
            "X": random_ram(wdata);
            default: begin
                $display("unknown operation %s in the stimulus file", op);
                errors++;
                test_errors++;
            end
        endcase
    endtask

    task automatic finish_test();
        if (cur_test != 0) begin
            tests++;
            if (test_errors == 0) begin
                $display("test %0d: ok", cur_test);
            end else begin
                $display("test %0d: %0d errors", cur_test, test_errors);
            end
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        int          fd;
        string       line;
        string       op;
        int          fields;
        int          test_id;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp;
        logic [3:0]  be;
        clk         = 1'b0;
        rst_n       = 1'b0;
        bus_req     = '0;
        fl_pending  = 1'b0;
        fl_addr     = 32'd0;
        timed_out   = 1'b0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        cur_test    = 0;
        void'($urandom(96));
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        fd = $fopen("bench/soc_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file bench/soc_stimulus.txt");
            errors++;
        end else begin
            for (int n = 0; n < MAX_LINES && !timed_out; n++) begin
                if ($fgets(line, fd) == 0) begin
                    break;
                end
                if (line.len() < 3 || line[0] == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%d %s %h %h %h %h", test_id, op, addr, wdata, be, exp);
                if (fields != 6) begin
                    $display("badly formed stimulus line: %s", line);
                    errors++;
                    continue;
                end
                if (test_id != cur_test) begin
                    finish_test();
                    cur_test    = test_id;
                    test_errors = 0;
                end
                run_op(op, addr, wdata, be, exp);
            end
            $fclose(fd);
            finish_test();
        end

        errors += UUT.u_flash_fsm.u_props.fail_count; // assertion failures.
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: hdl/dbus_decoder.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module dbus_decoder (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t bus_req_i,
    output soc_bus_pkg::bus_req_t ram_req_o,
    output soc_bus_pkg::bus_req_t flash_req_o,
    input  logic [31:0]           ram_rdata_i,
    input  logic [31:0]           flash_rdata_i,
    output logic [31:0]           bus_rdata_o
);

    import soc_bus_pkg::*;

    // upper address bits that select a window.
    localparam logic [31:0] RAM_MASK   = ~((32'd1 << (`RAM_AW + 2)) - 32'd1);
    localparam logic [31:0] FLASH_MASK = ~((32'd1 << `FLASH_WIN_AW) - 32'd1);

    logic        hit_ram;
    logic        hit_flash;
    bus_target_e rd_tgt_q;

    assign hit_ram   = (bus_req_i.addr & RAM_MASK) == `RAM_BASE;
    assign hit_flash = (bus_req_i.addr & FLASH_MASK) == `FLASH_BASE;

    // ==================================================
    // request fan-out
    // ==================================================

    always_comb begin
        ram_req_o      = bus_req_i;
        ram_req_o.addr = bus_req_i.addr & ~RAM_MASK; // offset in window.
        ram_req_o.rd   = bus_req_i.rd & hit_ram;
        ram_req_o.wr   = bus_req_i.wr & hit_ram;

        flash_req_o      = bus_req_i;
        flash_req_o.addr = bus_req_i.addr & ~FLASH_MASK;
        flash_req_o.rd   = bus_req_i.rd & hit_flash;
        flash_req_o.wr   = bus_req_i.wr & hit_flash;
    end

    // ==================================================
    // read return
    // ==================================================

    // slaves answer one cycle after the strobe, so remember who was asked.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_tgt_q <= TGT_NONE;
        end else if (bus_req_i.rd && hit_ram) begin
            rd_tgt_q <= TGT_RAM;
        end else if (bus_req_i.rd && hit_flash) begin
            rd_tgt_q <= TGT_FLASH;
        end else begin
            rd_tgt_q <= TGT_NONE; // unmapped or no read.
        end
    end

    always_comb begin
        case (rd_tgt_q)
            TGT_RAM:   bus_rdata_o = ram_rdata_i;
            TGT_FLASH: bus_rdata_o = flash_rdata_i;
            default:   bus_rdata_o = 32'd0;
        endcase
    end

endmodule

// File: hdl/flash_datapath.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module flash_datapath (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  soc_bus_pkg::bus_req_t req_i,
    input  logic                  busy_i,
    input  logic                  hi_sel_i,
    input  logic                  capture_lo_i,
    input  logic                  capture_hi_i,
    input  logic                  ce_n_i,
    input  logic                  oe_n_i,
    input  logic [15:0]           flash_data_i,
    output logic                  start_o,
    output flash_pkg::flash_pins_t flash_pins_o,
    output logic [31:0]           rdata_o
);

    import flash_pkg::*;

    flash_reg_e            reg_sel;
    logic [`FLASH_AW-2:0]  word_addr_q; // flash word address.
    logic [31:0]           data_q;

    assign reg_sel = flash_reg_e'(req_i.addr[3:0]);

    // new read only when idle, busy writes are dropped.
    assign start_o = req_i.wr && (reg_sel == FREG_ADDR) && !busy_i;

    // ==================================================
    // address and data registers
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            word_addr_q <= '0;
            data_q      <= 32'd0;
        end else begin
            if (start_o) begin
                word_addr_q <= req_i.wdata[`FLASH_AW:2]; // byte address in.
            end
            if (capture_lo_i) begin
                data_q[15:0] <= flash_data_i;
            end
            if (capture_hi_i) begin
                data_q[31:16] <= flash_data_i;
            end
        end
    end

    // halfword h = 2 * word, plus one for the high half.
    assign flash_pins_o.addr = {word_addr_q, hi_sel_i};
    assign flash_pins_o.ce_n = ce_n_i;
    assign flash_pins_o.oe_n = oe_n_i;

    // ==================================================
    // register readback
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rdata_o <= 32'd0;
        end else if (req_i.rd) begin
            case (reg_sel)
                FREG_ADDR:   rdata_o <= {{(32-`FLASH_AW-1){1'b0}}, word_addr_q, 2'b00};
                FREG_STATUS: rdata_o <= {31'd0, busy_i};
                FREG_DATA:   rdata_o <= data_q;
                default:     rdata_o <= 32'd0;
            endcase
        end
    end

endmodule

// File: hdl/flash_fsm.sv
`timescale 1ns/1ps

module flash_fsm (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic expired_i,
    output logic load_o,
    output logic capture_lo_o,
    output logic capture_hi_o,
    output logic hi_sel_o,
    output logic busy_o,
    output logic ce_n_o,
    output logic oe_n_o
);

    import flash_pkg::*;

    flash_state_e state_q;
    flash_state_e state_d;

    // ==================================================
    // next state and strobes
    // ==================================================

    always_comb begin
        state_d      = state_q;
        load_o       = 1'b0;
        capture_lo_o = 1'b0;
        capture_hi_o = 1'b0;
        case (state_q)
            FL_IDLE: begin
                if (start_i) begin
                    state_d = FL_READ_LO;
                    load_o  = 1'b1;
                end
            end
            FL_READ_LO: begin
                if (expired_i) begin
                    capture_lo_o = 1'b1;
                    load_o       = 1'b1; // second halfword wait.
                    state_d      = FL_READ_HI;
                end
            end
            FL_READ_HI: begin
                if (expired_i) begin
                    capture_hi_o = 1'b1;
                    state_d      = FL_IDLE;
                end
            end
            default: state_d = FL_IDLE;
        endcase
    end

    // ==================================================
    // state and registered pin controls
    // ==================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= FL_IDLE;
            busy_o   <= 1'b0;
            hi_sel_o <= 1'b0;
            ce_n_o   <= 1'b1;
            oe_n_o   <= 1'b1;
        end else begin
            state_q  <= state_d;
            busy_o   <= state_d != FL_IDLE;
            hi_sel_o <= state_d == FL_READ_HI;
            ce_n_o   <= state_d == FL_IDLE; // chip held for both halves.
            oe_n_o   <= state_d == FL_IDLE;
        end
    end

endmodule

// File: hdl/flash_pkg.sv
`include "soc_defines.svh"

package flash_pkg;

    // ==================================================
    // flash pins and controller types
    // ==================================================

    // outgoing pins, data comes back on a separate input.
    typedef struct packed {
        logic [`FLASH_AW-1:0] addr; // halfword address.
        logic                 ce_n;
        logic                 oe_n;
    } flash_pins_t;

    typedef enum logic [1:0] {
        FL_IDLE    = 2'd0,
        FL_READ_LO = 2'd1, // low halfword at h.
        FL_READ_HI = 2'd2  // high halfword at h+1.
    } flash_state_e;

    // register offsets inside the window.
    typedef enum logic [3:0] {
        FREG_ADDR   = 4'h0,
        FREG_STATUS = 4'h4,
        FREG_DATA   = 4'h8
    } flash_reg_e;

endpackage

// File: hdl/flash_wait_timer.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module flash_wait_timer (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic load_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(`FLASH_WAIT_CYCLES + 1);

    logic [CNT_W-1:0] count_q;
    logic             running_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            running_q <= 1'b0;
        end else if (load_i) begin
            count_q   <= CNT_W'(`FLASH_WAIT_CYCLES - 1); // reload wins over expiry.
            running_q <= 1'b1;
        end else if (running_q) begin
            if (count_q == '0) begin
                running_q <= 1'b0;
            end else begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // one pulse per load, on the last wait cycle.
    assign expired_o = running_q && (count_q == '0);

endmodule

// File: hdl/scratch_ram.sv
`timescale 1ns/1ps
`include "soc_defines.svh"

module scratch_ram (
    input  logic                  clk_i,
    input  soc_bus_pkg::bus_req_t req_i,
    output logic [31:0]           rdata_o
);

    localparam int DEPTH = 2 ** `RAM_AW;

    logic [31:0]         mem [DEPTH];
    logic [`RAM_AW-1:0]  word_addr;

    assign word_addr = req_i.addr[`RAM_AW+1:2]; // byte offset to word index.

    // write lanes under byte enables.
    always_ff @(posedge clk_i) begin
        if (req_i.wr) begin
            for (int i = 0; i < 4; i++) begin
                if (req_i.be[i]) begin
                    mem[word_addr][8*i +: 8] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // registered read, valid in the next cycle.
    always_ff @(posedge clk_i) begin
        if (req_i.rd) begin
            rdata_o <= mem[word_addr];
        end
    end

endmodule

// File: hdl/soc_bus_pkg.sv
package soc_bus_pkg;

    // ==================================================
    // data bus request
    // ==================================================

    // one master request, strobes valid for a single cycle.
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  be;    // byte lane enables.
        logic        rd;
        logic        wr;
        logic [31:0] wdata;
    } bus_req_t;

    // which slave owns the read data of the previous cycle.
    typedef enum logic [1:0] {
        TGT_NONE  = 2'd0,
        TGT_RAM   = 2'd1,
        TGT_FLASH = 2'd2
    } bus_target_e;

endpackage

// File: hdl/soc_defines.svh
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// ==================================================
// address map
// ==================================================

// scratch RAM window, 4 KB of words.
`define RAM_BASE 32'h8000_0000
`define RAM_AW 10

// flash controller register window.
`define FLASH_BASE 32'hBE00_0000
`define FLASH_WIN_AW 4 // 16 bytes, three registers used.

// ==================================================
// flash timing and geometry
// ==================================================

// wait cycles spent on each halfword access.
`define FLASH_WAIT_CYCLES 4

// halfword address width on the flash pins.
`define FLASH_AW 23

`endif

// File: hdl/soc_toplevel.sv
`timescale 1ns/1ps

module soc_toplevel (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  soc_bus_pkg::bus_req_t  bus_req_i,
    output logic [31:0]            bus_rdata_o,
    output flash_pkg::flash_pins_t flash_pins_o,
    input  logic [15:0]            flash_data_i
);

    import soc_bus_pkg::*;

    bus_req_t    ram_req;
    bus_req_t    flash_req;
    logic [31:0] ram_rdata;
    logic [31:0] flash_rdata;

    // flash control between fsm, timer and datapath.
    logic fl_start, fl_load, fl_expired;
    logic fl_capture_lo, fl_capture_hi;
    logic fl_hi_sel, fl_busy, fl_ce_n, fl_oe_n;

    // ==================================================
    // bus decode and RAM
    // ==================================================

    dbus_decoder u_decoder (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .bus_req_i     (bus_req_i),
        .ram_req_o     (ram_req),
        .flash_req_o   (flash_req),
        .ram_rdata_i   (ram_rdata),
        .flash_rdata_i (flash_rdata),
        .bus_rdata_o   (bus_rdata_o)
    );

    scratch_ram u_ram (
        .clk_i   (clk_i),
        .req_i   (ram_req),
        .rdata_o (ram_rdata)
    );

    // ==================================================
    // flash read controller
    // ==================================================

    flash_datapath u_flash_dp (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_i        (flash_req),
        .busy_i       (fl_busy),
        .hi_sel_i     (fl_hi_sel),
        .capture_lo_i (fl_capture_lo),
        .capture_hi_i (fl_capture_hi),
        .ce_n_i       (fl_ce_n),
        .oe_n_i       (fl_oe_n),
        .flash_data_i (flash_data_i),
        .start_o      (fl_start),
        .flash_pins_o (flash_pins_o),
        .rdata_o      (flash_rdata)
    );

    flash_fsm u_flash_fsm (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .start_i      (fl_start),
        .expired_i    (fl_expired),
        .load_o       (fl_load),
        .capture_lo_o (fl_capture_lo),
        .capture_hi_o (fl_capture_hi),
        .hi_sel_o     (fl_hi_sel),
        .busy_o       (fl_busy),
        .ce_n_o       (fl_ce_n),
        .oe_n_o       (fl_oe_n)
    );

    flash_wait_timer u_flash_timer (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .load_i    (fl_load),
        .expired_o (fl_expired)
    );

endmodule

// File: src.f
+incdir+hdl
hdl/soc_bus_pkg.sv
hdl/flash_pkg.sv
hdl/dbus_decoder.sv
hdl/scratch_ram.sv
hdl/flash_wait_timer.sv
hdl/flash_fsm.sv
hdl/flash_datapath.sv
hdl/soc_toplevel.sv
bench/soc_props.sv
bench/soc_tb.sv
